//--- build.f
mux_pkg.sv
rr_arbiter.sv
spill_reg.sv
w_route_fifo.sv
write_mux.sv
read_mux.sv
axi_mux_top.sv
tb_axi_mux.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the mux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_axi_mux \
  && ./obj_dir/Vtb_axi_mux | tee /dev/stderr | grep -q "^TEST PASSED$" \
  && echo "run_sim: simulation ok" \
  || { echo "run_sim: simulation failed"; exit 1; }

//--- tb_axi_mux.sv
`timescale 1ns/1ns

module tb_axi_mux import mux_pkg::*; ();

  // stop limit, tests need under 2000 cycles
  localparam int MAX_CYCLES = 5000;
  // write addresses per port, first run and total after the stall run
  localparam int WR_TXN_A   = 6;
  localparam int WR_TXN_B   = 9;
  // read addresses per port
  localparam int RD_TXN     = 8;
  localparam int TBL_DEPTH  = 16;

  // expected w burst, queued in downstream aw order
  typedef struct packed {
    int port;
    int txn;
    int len;
  } w_exp_t;

  // ------------------------------
  // dut signals
  // ------------------------------
  logic                     clk_i;
  logic                     arst_n_i;
  ax_chan_t [NUM_PORTS-1:0] slv_aw_i;
  logic     [NUM_PORTS-1:0] slv_aw_valid_i;
  logic     [NUM_PORTS-1:0] slv_aw_ready_o;
  w_chan_t  [NUM_PORTS-1:0] slv_w_i;
  logic     [NUM_PORTS-1:0] slv_w_valid_i;
  logic     [NUM_PORTS-1:0] slv_w_ready_o;
  b_chan_t  [NUM_PORTS-1:0] slv_b_o;
  logic     [NUM_PORTS-1:0] slv_b_valid_o;
  logic     [NUM_PORTS-1:0] slv_b_ready_i;
  ax_chan_t [NUM_PORTS-1:0] slv_ar_i;
  logic     [NUM_PORTS-1:0] slv_ar_valid_i;
  logic     [NUM_PORTS-1:0] slv_ar_ready_o;
  r_chan_t  [NUM_PORTS-1:0] slv_r_o;
  logic     [NUM_PORTS-1:0] slv_r_valid_o;
  logic     [NUM_PORTS-1:0] slv_r_ready_i;
  ax_chan_t                 mst_aw_o;
  logic                     mst_aw_valid_o;
  logic                     mst_aw_ready_i;
  w_chan_t                  mst_w_o;
  logic                     mst_w_valid_o;
  logic                     mst_w_ready_i;
  b_chan_t                  mst_b_i;
  logic                     mst_b_valid_i;
  logic                     mst_b_ready_o;
  ax_chan_t                 mst_ar_o;
  logic                     mst_ar_valid_o;
  logic                     mst_ar_ready_i;
  r_chan_t                  mst_r_i;
  logic                     mst_r_valid_i;
  logic                     mst_r_ready_o;

  // ------------------------------
  // testbench state
  // ------------------------------
  integer               seed;
  int                   err_cnt, chk_cnt, cycle_cnt;
  logic [LEN_W-1:0]     aw_len_tbl [NUM_PORTS][TBL_DEPTH];
  logic [LEN_W-1:0]     ar_len_tbl [NUM_PORTS][TBL_DEPTH];
  // per port manager progress
  int                   aw_limit [NUM_PORTS];
  int                   aw_sent  [NUM_PORTS];
  int                   ar_limit [NUM_PORTS];
  int                   ar_sent  [NUM_PORTS];
  int                   w_txn    [NUM_PORTS];
  int                   w_beat   [NUM_PORTS];
  // upstream handshakes seen mid cycle
  logic [NUM_PORTS-1:0] aw_fire, w_fire, ar_fire;
  // stimulus modes
  logic                 w_ready_low, w_ready_rand, ar_rand_en, b_rand_en, r_rand_en;
  // downstream progress
  int                   aw_cnt, ar_cnt, w_beat_cnt, w_burst_cnt, stall_base;
  w_exp_t               w_exp_q [$];

  axi_mux_top UUT (.*);

  // ------------------------------
  // reference model
  // ------------------------------
  // w data of port p, transaction n, beat k
  function automatic logic [DATA_W-1:0] ref_wdata(input int p, input int n, input int k);
    return {4'hc, p[3:0], n[7:0], k[7:0], 8'(p * 61 + n * 7 + k * 3)};
  endfunction

  // address beat of port p, transaction n
  function automatic ax_chan_t build_ax(input int p, input int n,
                                        input logic [LEN_W-1:0] len, input logic rd);
    ax_chan_t ax;
    ax.id.fld.port   = p[PORT_IDX_W-1:0];
    ax.id.fld.sub_id = n[SUB_ID_W-1:0];
    // read flag, port and txn in the address
    ax.addr          = {rd, p[1:0], n[7:0], 5'h15};
    ax.len           = len;
    return ax;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // ------------------------------
  // clock and timeout
  // ------------------------------
  initial begin : proc_clk
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : proc_timeout
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("error: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------
  // upstream managers and subordinate
  // ------------------------------
  // inputs move 1 ns after the edge
  always @(posedge clk_i) begin : proc_drive
    int      rnd;
    int      rnd2;
    w_chan_t w;
    #1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (aw_fire[p]) begin
        aw_sent[p]++;
      end
      if (ar_fire[p]) begin
        ar_sent[p]++;
      end
      // burst ends on its last beat
      if (w_fire[p]) begin
        if (w_beat[p] == int'(aw_len_tbl[p][w_txn[p]])) begin
          w_txn[p]++;
          w_beat[p] = 0;
        end else begin
          w_beat[p]++;
        end
      end
      slv_aw_valid_i[p] = (aw_sent[p] < aw_limit[p]);
      slv_aw_i[p]       = build_ax(p, aw_sent[p], aw_len_tbl[p][aw_sent[p]], 1'b0);
      slv_ar_valid_i[p] = (ar_sent[p] < ar_limit[p]);
      slv_ar_i[p]       = build_ax(p, ar_sent[p], ar_len_tbl[p][ar_sent[p]], 1'b1);
      // w may lead its own address
      w.data            = ref_wdata(p, w_txn[p], w_beat[p]);
      w.last            = (w_beat[p] == int'(aw_len_tbl[p][w_txn[p]]));
      slv_w_i[p]        = w;
      slv_w_valid_i[p]  = (w_txn[p] < aw_limit[p]);
    end
    // downstream readies
    rnd = $random(seed);
    if (w_ready_low) begin
      mst_w_ready_i = 1'b0;
    end else if (w_ready_rand) begin
      mst_w_ready_i = (rnd[1:0] != 2'b00);
    end else begin
      mst_w_ready_i = 1'b1;
    end
    mst_ar_ready_i = ar_rand_en ? rnd[2] : 1'b1;
    // b responses with chosen ids
    rnd = $random(seed);
    if (b_rand_en) begin
      mst_b_i       = b_chan_t'(rnd[5:0]);
      mst_b_valid_i = rnd[6];
      slv_b_ready_i = rnd[11:8];
    end else begin
      mst_b_i       = '0;
      mst_b_valid_i = 1'b0;
      slv_b_ready_i = '1;
    end
    // r beats with chosen ids
    rnd  = $random(seed);
    rnd2 = $random(seed);
    if (r_rand_en) begin
      mst_r_i       = r_chan_t'({rnd[6:0], rnd2});
      mst_r_valid_i = rnd[8];
      slv_r_ready_i = rnd[15:12];
    end else begin
      mst_r_i       = '0;
      mst_r_valid_i = 1'b0;
      slv_r_ready_i = '1;
    end
  end

  // ------------------------------
  // compare process
  // ------------------------------
  // mid cycle, all values settled
  always @(negedge clk_i) begin : proc_compare
    int        p;
    int        n;
    ax_chan_t  exp_ax;
    w_exp_t    we;
    port_idx_t bp;
    port_idx_t rp;
    aw_fire = slv_aw_valid_i & slv_aw_ready_o;
    w_fire  = slv_w_valid_i & slv_w_ready_o;
    ar_fire = slv_ar_valid_i & slv_ar_ready_o;
    if (arst_n_i) begin
      // aw grants cycle through the ports
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        p = aw_cnt % NUM_PORTS;
        n = aw_cnt / NUM_PORTS;
        if (n >= WR_TXN_B) begin
          err_cnt++;
          $display("error: more write addresses downstream than were sent");
        end else begin
          exp_ax = build_ax(p, n, aw_len_tbl[p][n], 1'b0);
          check_val("aw id", exp_ax.id.raw, mst_aw_o.id.raw);
          check_val("aw addr", exp_ax.addr, mst_aw_o.addr);
          check_val("aw len", exp_ax.len, mst_aw_o.len);
          we.port = p;
          we.txn  = n;
          we.len  = int'(exp_ax.len);
          w_exp_q.push_back(we);
        end
        aw_cnt++;
      end
      // w beats in aw order
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (w_exp_q.size() == 0) begin
          err_cnt++;
          $display("error: write data beat arrived with no open write address");
        end else begin
          we = w_exp_q[0];
          check_val("w data", ref_wdata(we.port, we.txn, w_beat_cnt), mst_w_o.data);
          check_val("w last", (w_beat_cnt == we.len), mst_w_o.last);
          if (w_beat_cnt == we.len) begin
            void'(w_exp_q.pop_front());
            w_beat_cnt = 0;
            w_burst_cnt++;
          end else begin
            w_beat_cnt++;
          end
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        p = ar_cnt % NUM_PORTS;
        n = ar_cnt / NUM_PORTS;
        if (n >= RD_TXN) begin
          err_cnt++;
          $display("error: more read addresses downstream than were sent");
        end else begin
          exp_ax = build_ax(p, n, ar_len_tbl[p][n], 1'b1);
          check_val("ar id", exp_ax.id.raw, mst_ar_o.id.raw);
          check_val("ar addr", exp_ax.addr, mst_ar_o.addr);
          check_val("ar len", exp_ax.len, mst_ar_o.len);
        end
        ar_cnt++;
      end
      // b and r go to the port in the id msbs only
      bp = mst_b_i.id.fld.port;
      rp = mst_r_i.id.fld.port;
      for (int i = 0; i < NUM_PORTS; i++) begin
        check_val($sformatf("b valid port %0d", i),
                  mst_b_valid_i && (int'(bp) == i), slv_b_valid_o[i]);
        check_val($sformatf("r valid port %0d", i),
                  mst_r_valid_i && (int'(rp) == i), slv_r_valid_o[i]);
        // payload reaches every port unchanged
        check_val($sformatf("b payload port %0d", i), mst_b_i, slv_b_o[i]);
        check_val($sformatf("r payload port %0d", i), mst_r_i, slv_r_o[i]);
      end
      check_val("b ready", slv_b_ready_i[bp], mst_b_ready_o);
      check_val("r ready", slv_r_ready_i[rp], mst_r_ready_o);
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : proc_main
    seed        = 32'h83d3cdab;
    err_cnt     = 0;
    chk_cnt     = 0;
    cycle_cnt   = 0;
    aw_cnt      = 0;
    ar_cnt      = 0;
    w_beat_cnt  = 0;
    w_burst_cnt = 0;
    stall_base  = 0;
    aw_fire     = '0;
    w_fire      = '0;
    ar_fire     = '0;
    w_ready_low = 1'b0;
    w_ready_rand = 1'b0;
    ar_rand_en  = 1'b0;
    b_rand_en   = 1'b0;
    r_rand_en   = 1'b0;
    // all dut inputs idle
    arst_n_i       = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = '0;
    slv_w_i        = '0;
    slv_w_valid_i  = '0;
    slv_b_ready_i  = '1;
    slv_ar_i       = '0;
    slv_ar_valid_i = '0;
    slv_r_ready_i  = '1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    mst_ar_ready_i = 1'b1;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    // random burst lengths
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_limit[p] = 0;
      aw_sent[p]  = 0;
      ar_limit[p] = 0;
      ar_sent[p]  = 0;
      w_txn[p]    = 0;
      w_beat[p]   = 0;
      for (int n = 0; n < TBL_DEPTH; n++) begin
        aw_len_tbl[p][n] = LEN_W'($random(seed));
        ar_len_tbl[p][n] = LEN_W'($random(seed));
      end
    end
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_val("idle aw valid", 1'b0, mst_aw_valid_o);
    check_val("idle ar valid", 1'b0, mst_ar_valid_o);
    check_val("idle w valid", 1'b0, mst_w_valid_o);
    check_val("idle w ready", '0, slv_w_ready_o);

    // aw round robin and w routing
    @(posedge clk_i);
    w_ready_rand = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_limit[p] = WR_TXN_A;
    end
    while (w_burst_cnt < NUM_PORTS * WR_TXN_A) begin
      @(posedge clk_i);
    end

    // routing queue fills, aw must stop
    w_ready_rand = 1'b0;
    w_ready_low  = 1'b1;
    stall_base   = aw_cnt;
    for (int p = 0; p < NUM_PORTS; p++) begin
      aw_limit[p] = WR_TXN_B;
    end
    repeat (40) @(posedge clk_i);
    check_val("aw transfers while w stalled", MAX_W_TRANS, aw_cnt - stall_base);
    @(negedge clk_i);
    check_val("upstream aw ready with queue full", '0, slv_aw_ready_o);
    @(posedge clk_i);
    w_ready_low = 1'b0;
    while (w_burst_cnt < NUM_PORTS * WR_TXN_B) begin
      @(posedge clk_i);
    end
    check_val("aw total", NUM_PORTS * WR_TXN_B, aw_cnt);

    // b routing
    b_rand_en = 1'b1;
    repeat (64) @(posedge clk_i);
    b_rand_en = 1'b0;

    // ar under random ready, r routing alongside
    ar_rand_en = 1'b1;
    r_rand_en  = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      ar_limit[p] = RD_TXN;
    end
    while (ar_cnt < NUM_PORTS * RD_TXN) begin
      @(posedge clk_i);
    end
    // no late duplicates
    repeat (10) @(posedge clk_i);
    check_val("ar total", NUM_PORTS * RD_TXN, ar_cnt);
    ar_rand_en = 1'b0;
    r_rand_en  = 1'b0;
    repeat (2) @(posedge clk_i);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- axi_mux_top.sv
`timescale 1ns/1ns

module axi_mux_top import mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // ------------------------------
  // upstream managers
  // ------------------------------
  input  ax_chan_t [NUM_PORTS-1:0] slv_aw_i,
  input  logic     [NUM_PORTS-1:0] slv_aw_valid_i,
  output logic     [NUM_PORTS-1:0] slv_aw_ready_o,
  input  w_chan_t  [NUM_PORTS-1:0] slv_w_i,
  input  logic     [NUM_PORTS-1:0] slv_w_valid_i,
  output logic     [NUM_PORTS-1:0] slv_w_ready_o,
  output b_chan_t  [NUM_PORTS-1:0] slv_b_o,
  output logic     [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic     [NUM_PORTS-1:0] slv_b_ready_i,
  input  ax_chan_t [NUM_PORTS-1:0] slv_ar_i,
  input  logic     [NUM_PORTS-1:0] slv_ar_valid_i,
  output logic     [NUM_PORTS-1:0] slv_ar_ready_o,
  output r_chan_t  [NUM_PORTS-1:0] slv_r_o,
  output logic     [NUM_PORTS-1:0] slv_r_valid_o,
  input  logic     [NUM_PORTS-1:0] slv_r_ready_i,
  // ------------------------------
  // downstream subordinate
  // ------------------------------
  output ax_chan_t                 mst_aw_o,
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output w_chan_t                  mst_w_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  input  b_chan_t                  mst_b_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o,
  output ax_chan_t                 mst_ar_o,
  output logic                     mst_ar_valid_o,
  input  logic                     mst_ar_ready_i,
  input  r_chan_t                  mst_r_i,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o
);

  // aw, w and b
  write_mux i_write_mux (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .slv_w_i        ( slv_w_i        ),
    .slv_w_valid_i  ( slv_w_valid_i  ),
    .slv_w_ready_o  ( slv_w_ready_o  ),
    .slv_b_o        ( slv_b_o        ),
    .slv_b_valid_o  ( slv_b_valid_o  ),
    .slv_b_ready_i  ( slv_b_ready_i  ),
    .mst_aw_o       ( mst_aw_o       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_w_o        ( mst_w_o        ),
    .mst_w_valid_o  ( mst_w_valid_o  ),
    .mst_w_ready_i  ( mst_w_ready_i  ),
    .mst_b_i        ( mst_b_i        ),
    .mst_b_valid_i  ( mst_b_valid_i  ),
    .mst_b_ready_o  ( mst_b_ready_o  )
  );

  // ar and r
  read_mux i_read_mux (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

endmodule

//--- read_mux.sv
`timescale 1ns/1ns

module read_mux import mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // upstream managers
  input  ax_chan_t [NUM_PORTS-1:0] slv_ar_i,
  input  logic     [NUM_PORTS-1:0] slv_ar_valid_i,
  output logic     [NUM_PORTS-1:0] slv_ar_ready_o,
  output r_chan_t  [NUM_PORTS-1:0] slv_r_o,
  output logic     [NUM_PORTS-1:0] slv_r_valid_o,
  input  logic     [NUM_PORTS-1:0] slv_r_ready_i,
  // downstream subordinate
  output ax_chan_t                 mst_ar_o,
  output logic                     mst_ar_valid_o,
  input  logic                     mst_ar_ready_i,
  input  r_chan_t                  mst_r_i,
  input  logic                     mst_r_valid_i,
  output logic                     mst_r_ready_o
);

  ax_chan_t  arb_ar;
  logic      arb_valid, arb_ready;
  port_idx_t r_port;

  // ------------------------------
  // ar channel
  // ------------------------------
  rr_arbiter i_ar_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_ar_valid_i ),
    .gnt_o    ( slv_ar_ready_o ),
    .data_i   ( slv_ar_i       ),
    .valid_o  ( arb_valid      ),
    .ready_i  ( arb_ready      ),
    .data_o   ( arb_ar         )
  );

  // one cycle to downstream, ready path cut here
  spill_reg i_ar_spill (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .valid_i  ( arb_valid      ),
    .ready_o  ( arb_ready      ),
    .data_i   ( arb_ar         ),
    .valid_o  ( mst_ar_valid_o ),
    .ready_i  ( mst_ar_ready_i ),
    .data_o   ( mst_ar_o       )
  );

  // ------------------------------
  // r channel
  // ------------------------------
  assign r_port        = mst_r_i.id.fld.port;
  assign mst_r_ready_o = slv_r_ready_i[r_port];

  // beat copied everywhere, valid steered by id
  always_comb begin : proc_r_route
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      slv_r_o[i] = mst_r_i;
    end
    slv_r_valid_o         = '0;
    slv_r_valid_o[r_port] = mst_r_valid_i;
  end

endmodule

//--- write_mux.sv
`timescale 1ns/1ns

module write_mux import mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // upstream managers
  input  ax_chan_t [NUM_PORTS-1:0] slv_aw_i,
  input  logic     [NUM_PORTS-1:0] slv_aw_valid_i,
  output logic     [NUM_PORTS-1:0] slv_aw_ready_o,
  input  w_chan_t  [NUM_PORTS-1:0] slv_w_i,
  input  logic     [NUM_PORTS-1:0] slv_w_valid_i,
  output logic     [NUM_PORTS-1:0] slv_w_ready_o,
  output b_chan_t  [NUM_PORTS-1:0] slv_b_o,
  output logic     [NUM_PORTS-1:0] slv_b_valid_o,
  input  logic     [NUM_PORTS-1:0] slv_b_ready_i,
  // downstream subordinate
  output ax_chan_t                 mst_aw_o,
  output logic                     mst_aw_valid_o,
  input  logic                     mst_aw_ready_i,
  output w_chan_t                  mst_w_o,
  output logic                     mst_w_valid_o,
  input  logic                     mst_w_ready_i,
  input  b_chan_t                  mst_b_i,
  input  logic                     mst_b_valid_i,
  output logic                     mst_b_ready_o
);

  ax_chan_t  arb_aw;
  logic      arb_valid, arb_ready;
  logic      spill_valid, spill_ready;
  logic      fifo_full, fifo_empty;
  logic      fifo_push, fifo_pop;
  port_idx_t fifo_idx;
  port_idx_t b_port;

  // ------------------------------
  // aw channel
  // ------------------------------
  rr_arbiter i_aw_arbiter (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_aw_valid_i ),
    .gnt_o    ( slv_aw_ready_o ),
    .data_i   ( slv_aw_i       ),
    .valid_o  ( arb_valid      ),
    .ready_i  ( arb_ready      ),
    .data_o   ( arb_aw         )
  );

  // full queue blocks aw, arbiter stays locked meanwhile
  assign spill_valid = arb_valid & ~fifo_full;
  assign arb_ready   = spill_ready & ~fifo_full;
  // remember which port owns the next w burst
  assign fifo_push   = spill_valid & spill_ready;

  w_route_fifo i_w_route_fifo (
    .clk_i    ( clk_i              ),
    .arst_n_i ( arst_n_i           ),
    .push_i   ( fifo_push          ),
    .data_i   ( arb_aw.id.fld.port ),
    .full_o   ( fifo_full          ),
    .empty_o  ( fifo_empty         ),
    .pop_i    ( fifo_pop           ),
    .data_o   ( fifo_idx           )
  );

  spill_reg i_aw_spill (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .valid_i  ( spill_valid    ),
    .ready_o  ( spill_ready    ),
    .data_i   ( arb_aw         ),
    .valid_o  ( mst_aw_valid_o ),
    .ready_i  ( mst_aw_ready_i ),
    .data_o   ( mst_aw_o       )
  );

  // ------------------------------
  // w channel
  // ------------------------------
  // queue head picks the port
  assign mst_w_o       = slv_w_i[fifo_idx];
  assign mst_w_valid_o = ~fifo_empty & slv_w_valid_i[fifo_idx];
  // burst done on the last beat
  assign fifo_pop      = mst_w_valid_o & mst_w_ready_i & mst_w_o.last;

  always_comb begin : proc_w_ready
    slv_w_ready_o           = '0;
    slv_w_ready_o[fifo_idx] = ~fifo_empty & mst_w_ready_i;
  end

  // ------------------------------
  // b channel
  // ------------------------------
  assign b_port        = mst_b_i.id.fld.port;
  assign mst_b_ready_o = slv_b_ready_i[b_port];

  // payload to all, valid only to the owner
  always_comb begin : proc_b_route
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      slv_b_o[i] = mst_b_i;
    end
    slv_b_valid_o         = '0;
    slv_b_valid_o[b_port] = mst_b_valid_i;
  end

endmodule

//--- w_route_fifo.sv
`timescale 1ns/1ns

module w_route_fifo import mux_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // write side, one entry per accepted aw
  input  logic      push_i,
  input  port_idx_t data_i,
  output logic      full_o,
  // read side, head steers the w beats
  output logic      empty_o,
  input  logic      pop_i,
  output port_idx_t data_o
);

  port_idx_t [MAX_W_TRANS-1:0] mem_q;
  logic      [FIFO_PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic      [FIFO_CNT_W-1:0]  cnt_q;

  logic push_ok, pop_ok;

  assign full_o  = (cnt_q == FIFO_CNT_W'(MAX_W_TRANS));
  assign empty_o = (cnt_q == '0);
  // registered head, no fall-through
  assign data_o  = mem_q[rd_ptr_q];

  // ignore requests that would over or underflow
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_ptrs
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : proc_mem
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- spill_reg.sv
`timescale 1ns/1ns

module spill_reg import mux_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  ax_chan_t data_i,
  // downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output ax_chan_t data_o
);

  // main slot takes every new beat
  logic     a_full_q;
  ax_chan_t a_data_q;
  // spill slot holds the older beat when output stalls
  logic     b_full_q;
  ax_chan_t b_data_q;

  logic a_fill, a_drain;
  logic b_fill, b_drain;

  // ------------------------------
  // slot control
  // ------------------------------
  assign a_fill  = valid_i & ready_o;
  // main slot empties whenever the spill slot is free
  assign a_drain = a_full_q & ~b_full_q;
  // stalled beat moves to the spill slot
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // flop outputs only, no path from ready_i
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // spill slot always holds the older beat
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_full
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin : proc_data
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

//--- rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter import mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // upstream valids and readies
  input  logic     [NUM_PORTS-1:0] req_i,
  output logic     [NUM_PORTS-1:0] gnt_o,
  input  ax_chan_t [NUM_PORTS-1:0] data_i,
  // single arbitrated output
  output logic                     valid_o,
  input  logic                     ready_i,
  output ax_chan_t                 data_o
);

  // port with top priority this cycle
  port_idx_t prio_q;
  // choice held while the output stalls
  logic      lock_q;
  port_idx_t lock_idx_q;

  port_idx_t pick_idx;
  logic      pick_found;
  port_idx_t sel_idx;

  // ------------------------------
  // round-robin pick
  // ------------------------------
  // first requester at or after the pointer
  always_comb begin : proc_pick
    pick_found = 1'b0;
    pick_idx   = prio_q;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      if (!pick_found && req_i[port_idx_t'((prio_q + i) % NUM_PORTS)]) begin
        pick_found = 1'b1;
        pick_idx   = port_idx_t'((prio_q + i) % NUM_PORTS);
      end
    end
  end

  // locked port wins over a fresh pick
  assign sel_idx = lock_q ? lock_idx_q : pick_idx;
  assign valid_o = lock_q ? req_i[lock_idx_q] : pick_found;
  assign data_o  = data_i[sel_idx];

  // only the selected port sees ready
  always_comb begin : proc_gnt
    gnt_o          = '0;
    gnt_o[sel_idx] = valid_o & ready_i;
  end

  // ------------------------------
  // lock and pointer state
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_state
    if (!arst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // hold the choice across a stall
      lock_q     <= valid_o & ~ready_i;
      lock_idx_q <= sel_idx;
      // after a transfer the next port goes first
      if (valid_o && ready_i) begin
        if (sel_idx == port_idx_t'(NUM_PORTS - 1)) begin
          prio_q <= '0;
        end else begin
          prio_q <= sel_idx + 1'b1;
        end
      end
    end
  end

endmodule

//--- mux_pkg.sv
package mux_pkg;

  // ------------------------------
  // bus sizes
  // ------------------------------
  // upstream managers sharing the one downstream port
  localparam int unsigned NUM_PORTS   = 4;
  // port index rides in the id msbs
  localparam int unsigned PORT_IDX_W  = 2;
  // id bits owned by the manager itself
  localparam int unsigned SUB_ID_W    = 2;
  localparam int unsigned ID_W        = PORT_IDX_W + SUB_ID_W;
  localparam int unsigned ADDR_W      = 16;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned LEN_W       = 4;
  localparam int unsigned RESP_W      = 2;
  // write addresses allowed to wait for their data
  localparam int unsigned MAX_W_TRANS = 8;
  // routing queue pointer and occupancy widths
  localparam int unsigned FIFO_PTR_W  = $clog2(MAX_W_TRANS);
  localparam int unsigned FIFO_CNT_W  = $clog2(MAX_W_TRANS + 1);

  // ------------------------------
  // id encoding
  // ------------------------------
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // split view of the id
  typedef struct packed {
    port_idx_t           port;
    logic [SUB_ID_W-1:0] sub_id;
  } axi_id_fields_t;

  // raw id on the wire, or port plus sub id for routing
  typedef union packed {
    logic [ID_W-1:0] raw;
    axi_id_fields_t  fld;
  } axi_id_u;

  // ------------------------------
  // channel payloads
  // ------------------------------
  // shared by aw and ar
  typedef struct packed {
    axi_id_u           id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ax_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    axi_id_u           id;
    logic [RESP_W-1:0] resp;
  } b_chan_t;

  typedef struct packed {
    axi_id_u           id;
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
  } r_chan_t;

endpackage
